//--- mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Byte address and store data widths
`define ADDR_SIZE 32
`define WORD_SIZE 32

// Refill lane width in bits
`define LANE_SIZE 128

// Low address bits covered by one lane
`define LANE_OFFSET 4

// Set associativity of both caches
`define NUM_WAYS 4
`define WAY_SIZE 2

`endif

//--- mem_pkg.sv
`default_nettype none

`include "mem_consts.svh"

package mem_pkg;

    // Store access size
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } memop_size_e;

    // Lane read with a one-cycle req strobe
    typedef struct packed {
        logic                  req;
        logic [`ADDR_SIZE-1:0] addr;
    } mm_rd_t;

    typedef struct packed {
        logic                  req;
        logic [`ADDR_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] data;
        memop_size_e           size;
    } mm_wr_t;

endpackage

`default_nettype wire

//--- cache_pkg.sv
`default_nettype none

`include "mem_consts.svh"

package cache_pkg;

    // Per-cycle view of one cache
    typedef struct packed {
        logic                  access;
        logic                  miss;
        logic [`ADDR_SIZE-1:0] addr;
        logic [`WAY_SIZE-1:0]  hit_way;
    } cache_port_t;

    typedef struct packed {
        logic                  valid;
        logic [`LANE_SIZE-1:0] data;
        logic [`WAY_SIZE-1:0]  way;
    } refill_t;

    typedef struct packed {
        logic                  valid;
        logic [`ADDR_SIZE-1:0] addr;
        logic [`WORD_SIZE-1:0] data;
        mem_pkg::memop_size_e  size;
    } store_req_t;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        DC_REQ  = 3'd1,
        DC_WAIT = 3'd2,
        IC_REQ  = 3'd3,
        IC_WAIT = 3'd4
    } mmu_state_e;

endpackage

`default_nettype wire

//--- plru_tree.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module plru_tree (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  cache_pkg::cache_port_t port_i,
    input  cache_pkg::refill_t     fill_i,
    output logic [`WAY_SIZE-1:0]   victim_o
);

    // Bit 0 is the root, bit 1 orders ways 0/1, bit 2 orders ways 2/3
    logic [`NUM_WAYS-2:0] tree_q;
    logic [`NUM_WAYS-2:0] tree_d;
    logic                 hit;

    function automatic logic [`NUM_WAYS-2:0] touch(
        input logic [`NUM_WAYS-2:0] tree,
        input logic [`WAY_SIZE-1:0] way
    );
        logic [`NUM_WAYS-2:0] upd;
        upd = tree;
        // Path bits point away from the touched way
        upd[0] = ~way[1];
        if (way[1]) begin
            upd[2] = ~way[0];
        end else begin
            upd[1] = ~way[0];
        end
        return upd;
    endfunction

    assign hit = port_i.access && !port_i.miss;

    // Hit first, then fill
    always_comb begin
        tree_d = tree_q;
        if (hit) begin
            tree_d = touch(tree_d, port_i.hit_way);
        end
        if (fill_i.valid) begin
            tree_d = touch(tree_d, fill_i.way);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tree_q <= '0;
        end else begin
            tree_q <= tree_d;
        end
    end

    assign victim_o = tree_q[0] ? {1'b1, tree_q[2]} : {1'b0, tree_q[1]};

    hit_way_known: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        hit |-> !$isunknown(port_i.hit_way)
    );

endmodule

`default_nettype wire

//--- mmu_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module mmu_arbiter (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  cache_pkg::cache_port_t dc_i,
    input  cache_pkg::cache_port_t ic_i,
    input  cache_pkg::store_req_t  dc_store_i,
    input  logic [`WAY_SIZE-1:0]   dc_victim_i,
    input  logic [`WAY_SIZE-1:0]   ic_victim_i,
    input  logic                   mm_rdy_i,
    input  logic [`LANE_SIZE-1:0]  mm_data_i,
    output mem_pkg::mm_rd_t        mm_rd_o,
    output mem_pkg::mm_wr_t        mm_wr_o,
    output cache_pkg::refill_t     dc_refill_o,
    output cache_pkg::refill_t     ic_refill_o
);

    import cache_pkg::*;

    mmu_state_e            state_q;
    mmu_state_e            state_d;
    logic                  dc_pend_q;
    logic                  ic_pend_q;
    logic [`ADDR_SIZE-1:0] dc_addr_q;
    logic [`ADDR_SIZE-1:0] ic_addr_q;
    logic                  dc_done;
    logic                  ic_done;
    logic                  dc_vld_q;
    logic                  ic_vld_q;
    logic [`LANE_SIZE-1:0] lane_q;
    logic [`WAY_SIZE-1:0]  way_q;

    function automatic logic [`ADDR_SIZE-1:0] lane_align(input logic [`ADDR_SIZE-1:0] addr);
        return {addr[`ADDR_SIZE-1:`LANE_OFFSET], {`LANE_OFFSET{1'b0}}};
    endfunction

    assign dc_done = (state_q == DC_WAIT) && mm_rdy_i;
    assign ic_done = (state_q == IC_WAIT) && mm_rdy_i;

    // One outstanding miss per cache
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dc_pend_q <= 1'b0;
            ic_pend_q <= 1'b0;
        end else begin
            if (dc_i.miss) begin
                dc_pend_q <= 1'b1;
            end else if (dc_done) begin
                dc_pend_q <= 1'b0;
            end
            if (ic_i.miss) begin
                ic_pend_q <= 1'b1;
            end else if (ic_done) begin
                ic_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (dc_i.miss) begin
            dc_addr_q <= lane_align(dc_i.addr);
        end
        if (ic_i.miss) begin
            ic_addr_q <= lane_align(ic_i.addr);
        end
    end

    // Data cache first from idle, then alternate
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (dc_pend_q) begin
                    state_d = DC_REQ;
                end else if (ic_pend_q) begin
                    state_d = IC_REQ;
                end
            end
            DC_REQ:  state_d = DC_WAIT;
            DC_WAIT: begin
                if (mm_rdy_i) begin
                    state_d = ic_pend_q ? IC_REQ : IDLE;
                end
            end
            IC_REQ:  state_d = IC_WAIT;
            IC_WAIT: begin
                if (mm_rdy_i) begin
                    state_d = dc_pend_q ? DC_REQ : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= IDLE;
            dc_vld_q <= 1'b0;
            ic_vld_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            dc_vld_q <= dc_done;
            ic_vld_q <= ic_done;
        end
    end

    // Only one refill in flight, so both caches share the lane register
    always_ff @(posedge clk_i) begin
        if (dc_done || ic_done) begin
            lane_q <= mm_data_i;
            way_q  <= dc_done ? dc_victim_i : ic_victim_i;
        end
    end

    assign mm_rd_o.req  = (state_q == DC_REQ) || (state_q == IC_REQ);
    assign mm_rd_o.addr = (state_q == IC_REQ) ? ic_addr_q : dc_addr_q;

    assign dc_refill_o.valid = dc_vld_q;
    assign dc_refill_o.data  = lane_q;
    assign dc_refill_o.way   = way_q;
    assign ic_refill_o.valid = ic_vld_q;
    assign ic_refill_o.data  = lane_q;
    assign ic_refill_o.way   = way_q;

    // Store bypass
    assign mm_wr_o.req  = dc_store_i.valid;
    assign mm_wr_o.addr = dc_store_i.addr;
    assign mm_wr_o.data = dc_store_i.data;
    assign mm_wr_o.size = dc_store_i.size;

    // A read goes out only for a cache whose miss is still pending
    rd_req_pending: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        mm_rd_o.req |-> ((state_q == IC_REQ) ? ic_pend_q : dc_pend_q)
    );

    dc_miss_not_pending: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        dc_i.miss |-> !dc_pend_q
    );

    ic_miss_not_pending: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ic_i.miss |-> !ic_pend_q
    );

    rdy_not_idle: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        mm_rdy_i |-> state_q != IDLE
    );

endmodule

`default_nettype wire

//--- mmu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module mmu_top (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  cache_pkg::cache_port_t dc_i,
    input  cache_pkg::cache_port_t ic_i,
    input  cache_pkg::store_req_t  dc_store_i,
    input  logic                   mm_rdy_i,
    input  logic [`LANE_SIZE-1:0]  mm_data_i,
    output mem_pkg::mm_rd_t        mm_rd_o,
    output mem_pkg::mm_wr_t        mm_wr_o,
    output cache_pkg::refill_t     dc_refill_o,
    output cache_pkg::refill_t     ic_refill_o
);

    logic [`WAY_SIZE-1:0] dc_victim;
    logic [`WAY_SIZE-1:0] ic_victim;

    mmu_arbiter u_arbiter (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .dc_i        (dc_i),
        .ic_i        (ic_i),
        .dc_store_i  (dc_store_i),
        .dc_victim_i (dc_victim),
        .ic_victim_i (ic_victim),
        .mm_rdy_i    (mm_rdy_i),
        .mm_data_i   (mm_data_i),
        .mm_rd_o     (mm_rd_o),
        .mm_wr_o     (mm_wr_o),
        .dc_refill_o (dc_refill_o),
        .ic_refill_o (ic_refill_o)
    );

    // Each tracker also sees its own refills
    plru_tree u_dc_lru (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .port_i   (dc_i),
        .fill_i   (dc_refill_o),
        .victim_o (dc_victim)
    );

    plru_tree u_ic_lru (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .port_i   (ic_i),
        .fill_i   (ic_refill_o),
        .victim_o (ic_victim)
    );

endmodule

`default_nettype wire

//--- mm_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module mm_model (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  mem_pkg::mm_rd_t       rd_i,
    output logic                  rdy_o,
    output logic [`LANE_SIZE-1:0] data_o
);

    integer                seed;
    logic [`ADDR_SIZE-1:0] addr_q;
    logic [3:0]            wait_q;
    logic                  busy_q;

    // Every address bit reaches the lane
    function automatic logic [`LANE_SIZE-1:0] lane_for(input logic [`ADDR_SIZE-1:0] addr);
        return {addr ^ 32'h5a5a_c3c3, ~addr, {addr[15:0], addr[31:16]}, addr + 32'h0101_0101};
    endfunction

    initial seed = 27;

    always @(negedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdy_o  <= 1'b0;
            data_o <= '0;
            addr_q <= '0;
            wait_q <= '0;
            busy_q <= 1'b0;
        end else begin
            rdy_o <= 1'b0;
            if (rd_i.req) begin
                addr_q <= rd_i.addr;
                busy_q <= 1'b1;
                // Latency of 1 to 8 cycles
                wait_q <= 4'(1 + ($unsigned($random(seed)) % 8));
            end else if (busy_q) begin
                if (wait_q == 4'd1) begin
                    rdy_o  <= 1'b1;
                    data_o <= lane_for(addr_q);
                    busy_q <= 1'b0;
                end
                wait_q <= wait_q - 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- mmu_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_consts.svh"

module mmu_top_tb;

    import mem_pkg::*;
    import cache_pkg::*;

    localparam int MAX_LAT    = 8;
    localparam int NUM_RANDOM = 200;
    localparam int LIMIT      = (NUM_RANDOM + 20) * (MAX_LAT + 4) + 500;
    localparam logic [`ADDR_SIZE-1:0] LANE_MASK =
        ~((`ADDR_SIZE'(1) << `LANE_OFFSET) - `ADDR_SIZE'(1));
    localparam logic [1:0] HIT_SEQ [5] = '{2'd2, 2'd0, 2'd3, 2'd1, 2'd3};

    // Victim sits on the side each bit points to
    typedef struct packed {
        logic root;
        logic lo;
        logic hi;
    } tree_t;

    logic                  clk;
    logic                  arst_n;
    cache_port_t           dc_in;
    cache_port_t           ic_in;
    store_req_t            dc_store;
    logic                  mm_rdy;
    logic [`LANE_SIZE-1:0] mm_data;
    mm_rd_t                mm_rd;
    mm_wr_t                mm_wr;
    mm_wr_t                exp_wr;
    refill_t               dc_refill;
    refill_t               ic_refill;
    logic                  dc_p;
    logic                  ic_p;
    logic                  in_req;
    logic                  in_wait;
    logic                  srv_ic;
    logic [`ADDR_SIZE-1:0] exp_addr;
    refill_t               dc_exp;
    refill_t               ic_exp;
    tree_t                 dc_tree;
    tree_t                 ic_tree;
    logic [`ADDR_SIZE-1:0] dc_q[$];
    logic [`ADDR_SIZE-1:0] ic_q[$];
    int                    cycles = 0;
    integer                seed;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    mmu_top u_mmu_top (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .dc_i        (dc_in),
        .ic_i        (ic_in),
        .dc_store_i  (dc_store),
        .mm_rdy_i    (mm_rdy),
        .mm_data_i   (mm_data),
        .mm_rd_o     (mm_rd),
        .mm_wr_o     (mm_wr),
        .dc_refill_o (dc_refill),
        .ic_refill_o (ic_refill)
    );

    mm_model u_mm_model (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .rd_i     (mm_rd),
        .rdy_o    (mm_rdy),
        .data_o   (mm_data)
    );

    function automatic logic [`LANE_SIZE-1:0] expected_lane(input logic [`ADDR_SIZE-1:0] addr);
        return {addr ^ 32'h5a5a_c3c3, ~addr, {addr[15:0], addr[31:16]}, addr + 32'h0101_0101};
    endfunction

    function automatic tree_t touch_way(input tree_t t, input logic [1:0] way);
        tree_t n;
        n = t;
        case (way)
            2'd0: begin n.root = 1'b1; n.lo = 1'b1; end
            2'd1: begin n.root = 1'b1; n.lo = 1'b0; end
            2'd2: begin n.root = 1'b0; n.hi = 1'b1; end
            default: begin n.root = 1'b0; n.hi = 1'b0; end
        endcase
        return n;
    endfunction

    function automatic logic [1:0] victim_of(input tree_t t);
        return t.root ? {1'b1, t.hi} : {1'b0, t.lo};
    endfunction

    function automatic cache_port_t cache_access(input logic miss,
                                                 input logic [`ADDR_SIZE-1:0] addr,
                                                 input logic [1:0] way);
        return '{1'b1, miss, addr, way};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(negedge clk);
        dc_in    = '0;
        ic_in    = '0;
        dc_store = '0;
    endtask

    task automatic wait_drained();
        next_cycle();
        while (dc_p || ic_p || dc_exp.valid || ic_exp.valid) begin
            next_cycle();
        end
    endtask

    assign exp_wr = '{dc_store.valid, dc_store.addr, dc_store.data, dc_store.size};

    // Expected service order, refills and tree bits
    always @(posedge clk or negedge arst_n) begin
        tree_t                 dt;
        tree_t                 it;
        logic [`ADDR_SIZE-1:0] done_addr;
        if (!arst_n) begin
            dc_p     <= 1'b0;
            ic_p     <= 1'b0;
            in_req   <= 1'b0;
            in_wait  <= 1'b0;
            srv_ic   <= 1'b0;
            exp_addr <= '0;
            dc_exp   <= '0;
            ic_exp   <= '0;
            dc_tree  <= '0;
            ic_tree  <= '0;
            dc_q.delete();
            ic_q.delete();
        end else begin
            dt = dc_tree;
            it = ic_tree;
            if (dc_in.access && !dc_in.miss)
                dt = touch_way(dt, dc_in.hit_way);
            if (ic_in.access && !ic_in.miss)
                it = touch_way(it, ic_in.hit_way);
            if (dc_exp.valid)
                dt = touch_way(dt, dc_exp.way);
            if (ic_exp.valid)
                it = touch_way(it, ic_exp.way);
            dc_tree      <= dt;
            ic_tree      <= it;
            dc_exp.valid <= 1'b0;
            ic_exp.valid <= 1'b0;
            if (dc_in.miss) begin
                dc_p <= 1'b1;
                dc_q.push_back(dc_in.addr & LANE_MASK);
            end
            if (ic_in.miss) begin
                ic_p <= 1'b1;
                ic_q.push_back(ic_in.addr & LANE_MASK);
            end
            if (in_req) begin
                in_req  <= 1'b0;
                in_wait <= 1'b1;
            end else if (in_wait && mm_rdy) begin
                in_wait <= 1'b0;
                if (srv_ic) begin
                    done_addr = ic_q.pop_front();
                    ic_p   <= 1'b0;
                    ic_exp <= '{1'b1, expected_lane(done_addr), victim_of(ic_tree)};
                end else begin
                    done_addr = dc_q.pop_front();
                    dc_p   <= 1'b0;
                    dc_exp <= '{1'b1, expected_lane(done_addr), victim_of(dc_tree)};
                end
                // Hand over to the other cache if it waits
                if (srv_ic ? dc_p : ic_p) begin
                    in_req   <= 1'b1;
                    srv_ic   <= !srv_ic;
                    exp_addr <= srv_ic ? dc_q[0] : ic_q[0];
                end
            end else if (!in_wait && (dc_p || ic_p)) begin
                in_req   <= 1'b1;
                srv_ic   <= !dc_p;
                exp_addr <= dc_p ? dc_q[0] : ic_q[0];
            end
        end
    end

    req_check: assert property (@(posedge clk) disable iff (!arst_n) mm_rd.req == in_req)
        else stop_on_error($sformatf("Fail mm_rd_o.req got %h exp %h",
                                     $sampled(mm_rd.req), $sampled(in_req)));

    addr_check: assert property (@(posedge clk) disable iff (!arst_n)
        in_req |-> mm_rd.addr == exp_addr)
        else stop_on_error($sformatf("Fail mm_rd_o.addr got %h exp %h",
                                     $sampled(mm_rd.addr), $sampled(exp_addr)));

    dc_valid_check: assert property (@(posedge clk) disable iff (!arst_n)
        dc_refill.valid == dc_exp.valid)
        else stop_on_error($sformatf("Fail dc_refill_o.valid got %h exp %h",
                                     $sampled(dc_refill.valid), $sampled(dc_exp.valid)));

    ic_valid_check: assert property (@(posedge clk) disable iff (!arst_n)
        ic_refill.valid == ic_exp.valid)
        else stop_on_error($sformatf("Fail ic_refill_o.valid got %h exp %h",
                                     $sampled(ic_refill.valid), $sampled(ic_exp.valid)));

    dc_fill_check: assert property (@(posedge clk) disable iff (!arst_n)
        dc_exp.valid |-> dc_refill == dc_exp)
        else stop_on_error($sformatf("Fail dc_refill_o got %h exp %h",
                                     $sampled(dc_refill), $sampled(dc_exp)));

    ic_fill_check: assert property (@(posedge clk) disable iff (!arst_n)
        ic_exp.valid |-> ic_refill == ic_exp)
        else stop_on_error($sformatf("Fail ic_refill_o got %h exp %h",
                                     $sampled(ic_refill), $sampled(ic_exp)));

    store_check: assert property (@(posedge clk) disable iff (!arst_n) mm_wr == exp_wr)
        else stop_on_error($sformatf("Fail mm_wr_o got %h exp %h",
                                     $sampled(mm_wr), $sampled(exp_wr)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT)
            stop_on_error($sformatf("Run did not finish within %0d cycles", LIMIT));
    end

    initial begin
        logic [31:0] r;
        seed     = 27;
        arst_n   = 1'b0;
        dc_in    = '0;
        ic_in    = '0;
        dc_store = '0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        repeat (5) next_cycle();

        // Single data miss, store while it waits
        dc_in = cache_access(1'b1, 32'h0000_1234, 2'd0);
        next_cycle();
        dc_store = '{1'b1, 32'h8000_0010, 32'hdead_beef, SIZE_WORD};
        wait_drained();

        // Both miss together, then a data miss during instruction service
        dc_in = cache_access(1'b1, 32'h2000_0048, 2'd0);
        ic_in = cache_access(1'b1, 32'h3000_00a4, 2'd0);
        next_cycle();
        while (!(in_wait && srv_ic)) begin
            next_cycle();
        end
        dc_in = cache_access(1'b1, 32'h2000_1108, 2'd0);
        wait_drained();

        // Hits over the ways, then a miss on each cache
        for (int i = 0; i < 5; i++) begin
            dc_in = cache_access(1'b0, 32'h0000_0100, HIT_SEQ[i]);
            ic_in = cache_access(1'b0, 32'h0000_0200, ~HIT_SEQ[i]);
            next_cycle();
        end
        dc_in = cache_access(1'b1, 32'h5000_0030, 2'd0);
        ic_in = cache_access(1'b1, 32'h6000_0070, 2'd0);
        wait_drained();

        repeat (NUM_RANDOM) begin
            r = $random(seed);
            if (!dc_p && r[1:0] == 2'd0) begin
                dc_in = cache_access(1'b1, $random(seed), 2'd0);
            end else if (r[2]) begin
                dc_in = cache_access(1'b0, $random(seed), r[4:3]);
            end
            if (!ic_p && r[9:8] == 2'd0) begin
                ic_in = cache_access(1'b1, $random(seed), 2'd0);
            end else if (r[10]) begin
                ic_in = cache_access(1'b0, $random(seed), r[12:11]);
            end
            if (r[16]) begin
                dc_store = '{1'b1, $random(seed), $random(seed),
                             r[18] ? SIZE_WORD : (r[17] ? SIZE_HALF : SIZE_BYTE)};
            end
            next_cycle();
        end
        wait_drained();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- mmu_top.f
+incdir+.
mem_pkg.sv
cache_pkg.sv
plru_tree.sv
mmu_arbiter.sv
mmu_top.sv
mm_model.sv
mmu_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the MMU testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f mmu_top.f --top-module mmu_top_tb -o mmu_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit $build_status
fi

./obj_dir/mmu_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

exit 0
